// ==== verilog/rx_pkg.sv ====
`default_nettype none

package rx_pkg;

   ////////////////////
   // Sizes
   localparam int NUM_CHANNELS = 2;
   localparam int CHAN_W       = $clog2(NUM_CHANNELS);   // Channel tag on the output
   localparam int SET_ADDR_W   = 8;
   localparam int SET_DATA_W   = 32;
   localparam int ADC_W        = 14;
   localparam int SAMPLE_W     = 16;
   localparam int LED_W        = 8;
   localparam int DEC_W        = 16;   // Decimation register
   localparam int BURST_W      = 16;   // Burst length counter

   ////////////////////
   // Settings register map
   localparam int SR_MISC        = 0;    // LED sw at +3, LED source at +6
   localparam int SR_RX_FRONT    = 24;   // Swap, I offset, Q offset
   localparam int SR_RX_CTRL0    = 32;   // Channel 0 block
   localparam int RX_CTRL_STRIDE = 16;

   // 1 = hardware drives the LED, 0 = software value
   localparam logic [LED_W-1:0] LED_SRC_AT_RESET = 8'h1E;

   localparam int CHAN_FIFO_DEPTH  = 16;
   localparam int MERGE_FIFO_DEPTH = 4;

   ////////////////////
   // Payloads
   typedef struct packed {
      logic signed [SAMPLE_W-1:0] i;
      logic signed [SAMPLE_W-1:0] q;
   } iq_sample_t;

   typedef struct packed {
      logic       sof;
      logic       eof;
      iq_sample_t iq;
   } rx_word_t;

   typedef struct packed {
      logic [CHAN_W-1:0] chan;
      rx_word_t          word;
   } out_word_t;

endpackage

`default_nettype wire

// ==== verilog/rx_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Framed word stream, channel to merger
interface rx_stream_if;
   import rx_pkg::*;

   iq_sample_t data;
   logic       sof;
   logic       eof;
   logic       valid;
   logic       ready;   // Word moves when valid and ready

   modport source (output data, output sof, output eof, output valid, input ready);
   modport sink   (input data, input sof, input eof, input valid, output ready);

endinterface

`default_nettype wire

// ==== verilog/sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
   parameter type T     = logic [31:0],
   parameter int  DEPTH = 16
) (
   input  wire   dsp_clk,
   input  wire   por_rst,
   input  wire   flush_i,
   input  wire T wr_data_i,
   input  wire   wr_valid_i,
   output logic  wr_ready_o,
   output T      rd_data_o,
   output logic  rd_valid_o,
   input  wire   rd_ready_i
);

   localparam int AW = $clog2(DEPTH);

   T            mem [DEPTH];
   logic [AW:0] wr_ptr;   // Top bit marks the lap
   logic [AW:0] rd_ptr;
   logic        full;
   logic        empty;
   logic        do_wr;
   logic        do_rd;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign wr_ready_o = !full;
   assign rd_valid_o = !empty;
   assign rd_data_o  = mem[rd_ptr[AW-1:0]];   // Head word shows without a read

   assign do_wr = wr_valid_i && !full;
   assign do_rd = rd_ready_i && !empty;

   always_ff @(posedge dsp_clk) begin
      if (do_wr) begin
         mem[wr_ptr[AW-1:0]] <= wr_data_i;
      end
   end

   ////////////////////
   // Pointers
   always_ff @(posedge dsp_clk) begin
      if (por_rst || flush_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/rx_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_frontend (
   input  wire                          dsp_clk,
   input  wire                          por_rst,
   input  wire                          set_stb_i,
   input  wire [rx_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  wire [rx_pkg::SET_DATA_W-1:0] set_data_i,
   input  wire [rx_pkg::ADC_W-1:0]      adc_a_i,
   input  wire [rx_pkg::ADC_W-1:0]      adc_b_i,
   input  wire                          run_i,
   output rx_pkg::iq_sample_t           fe_sample_o
);
   import rx_pkg::*;

   logic                swap_iq;
   logic [SAMPLE_W-1:0] ofs_i;
   logic [SAMPLE_W-1:0] ofs_q;
   logic [SAMPLE_W-1:0] pad_a;
   logic [SAMPLE_W-1:0] pad_b;
   logic [SAMPLE_W-1:0] rail_i;
   logic [SAMPLE_W-1:0] rail_q;

   ////////////////////
   // Frontend registers
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         swap_iq <= 1'b0;
         ofs_i   <= '0;
         ofs_q   <= '0;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SET_ADDR_W'(SR_RX_FRONT + 0): swap_iq <= set_data_i[0];
            SET_ADDR_W'(SR_RX_FRONT + 1): ofs_i   <= set_data_i[SAMPLE_W-1:0];
            SET_ADDR_W'(SR_RX_FRONT + 2): ofs_q   <= set_data_i[SAMPLE_W-1:0];
            default: ;
         endcase
      end
   end

   // 14-bit ADC sits in the top of the rail
   assign pad_a = {adc_a_i, {(SAMPLE_W - ADC_W){1'b0}}};
   assign pad_b = {adc_b_i, {(SAMPLE_W - ADC_W){1'b0}}};

   assign rail_i = swap_iq ? pad_b : pad_a;
   assign rail_q = swap_iq ? pad_a : pad_b;

   // Idle channels see zeros
   always_ff @(posedge dsp_clk) begin
      if (por_rst || !run_i) begin
         fe_sample_o <= '0;
      end else begin
         fe_sample_o.i <= rail_i + ofs_i;   // Wraps
         fe_sample_o.q <= rail_q + ofs_q;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/rx_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_channel #(
   parameter int BASE = rx_pkg::SR_RX_CTRL0
) (
   input  wire                          dsp_clk,
   input  wire                          por_rst,
   input  wire                          set_stb_i,
   input  wire [rx_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  wire [rx_pkg::SET_DATA_W-1:0] set_data_i,
   input  wire rx_pkg::iq_sample_t      fe_sample_i,
   rx_stream_if.source                  out_o,
   output logic                         running_o,
   output logic                         overrun_o
);
   import rx_pkg::*;

   logic [DEC_W-1:0]   dec_n;
   logic [DEC_W-1:0]   dec_eff;
   logic [DEC_W-1:0]   phase;     // Cycles to the next take
   logic [BURST_W-1:0] remain;    // Words left in the burst
   logic               first;
   logic               take;
   logic               take_q;    // Write pending for last take
   logic               sof_q;
   logic               eof_q;
   logic               hit_dec;
   logic               hit_len;
   logic               hit_stop;
   logic               fifo_ready;
   logic               drop;
   rx_word_t           wr_word;
   rx_word_t           rd_word;

   assign hit_dec  = set_stb_i && (set_addr_i == SET_ADDR_W'(BASE + 0));
   assign hit_len  = set_stb_i && (set_addr_i == SET_ADDR_W'(BASE + 1));
   assign hit_stop = set_stb_i && (set_addr_i == SET_ADDR_W'(BASE + 2));

   assign dec_eff = (dec_n == '0) ? DEC_W'(1) : dec_n;   // 0 behaves as 1
   assign take    = running_o && (phase == '0);
   assign drop    = take_q && !fifo_ready;                 // FIFO full, sample lost

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         dec_n <= '0;
      end else if (hit_dec) begin
         dec_n <= set_data_i[DEC_W-1:0];
      end
   end

   ////////////////////
   // Burst control
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         running_o <= 1'b0;
         overrun_o <= 1'b0;
         take_q    <= 1'b0;
         first     <= 1'b0;
         sof_q     <= 1'b0;
         eof_q     <= 1'b0;
         phase     <= '0;
         remain    <= '0;
      end else begin
         take_q <= take && !drop && !hit_stop && !hit_len;
         if (take) begin
            sof_q  <= first;
            eof_q  <= (remain == BURST_W'(1));
            first  <= 1'b0;
            remain <= remain - 1'b1;
            phase  <= dec_eff - 1'b1;
            if (remain == BURST_W'(1)) begin
               running_o <= 1'b0;   // Last word of the burst
            end
         end else if (running_o) begin
            phase <= phase - 1'b1;
         end
         if (drop) begin
            overrun_o <= 1'b1;
            running_o <= 1'b0;
         end
         if (hit_len) begin
            remain    <= set_data_i[BURST_W-1:0];
            running_o <= (set_data_i[BURST_W-1:0] != '0);
            overrun_o <= 1'b0;
            first     <= 1'b1;
            phase     <= '0;
         end
         if (hit_stop) begin
            running_o <= 1'b0;
         end
      end
   end

   // Sample lands one cycle after its take, once the frontend has it
   assign wr_word = {sof_q, eof_q, fe_sample_i};

   sample_fifo #(
      .T     (rx_word_t),
      .DEPTH (CHAN_FIFO_DEPTH)
   ) u_fifo (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .flush_i    (hit_stop),
      .wr_data_i  (wr_word),
      .wr_valid_i (take_q),
      .wr_ready_o (fifo_ready),
      .rd_data_o  (rd_word),
      .rd_valid_o (out_o.valid),
      .rd_ready_i (out_o.ready)
   );

   assign out_o.data = rd_word.iq;
   assign out_o.sof  = rd_word.sof;
   assign out_o.eof  = rd_word.eof;

endmodule

`default_nettype wire

// ==== verilog/rx_merger.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_merger (
   input  wire                              dsp_clk,
   input  wire                              por_rst,
   rx_stream_if.sink                        chan_i [rx_pkg::NUM_CHANNELS],
   input  wire [rx_pkg::NUM_CHANNELS-1:0]   running_i,
   output logic [2*rx_pkg::SAMPLE_W-1:0]    rx_data_o,
   output logic                             rx_sof_o,
   output logic                             rx_eof_o,
   output logic [rx_pkg::CHAN_W-1:0]        rx_chan_o,
   output logic                             rx_valid_o,
   input  wire                              rx_ready_i
);
   import rx_pkg::*;

   logic [NUM_CHANNELS-1:0] valid_v;
   logic [NUM_CHANNELS-1:0] ready_v;
   logic [NUM_CHANNELS-1:0] running_q;   // Running one cycle back
   rx_word_t                word_v [NUM_CHANNELS];
   logic                    busy;      // Locked on a burst
   logic [CHAN_W-1:0]       cur;       // Channel served, or served last
   logic [CHAN_W-1:0]       pick;
   logic                    pick_ok;
   logic                    fire;
   logic                    release_cur;
   logic                    merge_ready;
   out_word_t               wr_word;
   out_word_t               rd_word;

   // Flatten the interface array
   for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_port
      assign valid_v[g]      = chan_i[g].valid;
      assign word_v[g]       = {chan_i[g].sof, chan_i[g].eof, chan_i[g].data};
      assign ready_v[g]      = fire && (cur == CHAN_W'(g));
      assign chan_i[g].ready = ready_v[g];
   end

   ////////////////////
   // Round-robin pick
   always_comb begin
      int idx;
      pick_ok = 1'b0;
      pick    = cur;
      for (int k = 1; k <= NUM_CHANNELS; k++) begin
         idx = (int'(cur) + k) % NUM_CHANNELS;   // Start after the last one
         if (!pick_ok && valid_v[idx]) begin
            pick_ok = 1'b1;
            pick    = CHAN_W'(idx);
         end
      end
   end

   assign fire = busy && valid_v[cur] && merge_ready;

   // The last take reaches the channel FIFO one cycle after running drops
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         running_q <= '0;
      end else begin
         running_q <= running_i;
      end
   end

   // Done at eof, or when a cut-short burst has drained
   assign release_cur = busy && ((fire && word_v[cur].eof) ||
                                 (!valid_v[cur] && !running_i[cur] && !running_q[cur]));

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         busy <= 1'b0;
         cur  <= CHAN_W'(NUM_CHANNELS - 1);   // Channel 0 goes first
      end else if (!busy) begin
         if (pick_ok) begin
            busy <= 1'b1;
            cur  <= pick;
         end
      end else if (release_cur) begin
         busy <= 1'b0;
      end
   end

   assign wr_word = {cur, word_v[cur]};

   sample_fifo #(
      .T     (out_word_t),
      .DEPTH (MERGE_FIFO_DEPTH)
   ) u_fifo (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .flush_i    (1'b0),
      .wr_data_i  (wr_word),
      .wr_valid_i (fire),
      .wr_ready_o (merge_ready),
      .rd_data_o  (rd_word),
      .rd_valid_o (rx_valid_o),
      .rd_ready_i (rx_ready_i)
   );

   assign rx_data_o = rd_word.word.iq;
   assign rx_sof_o  = rd_word.word.sof;
   assign rx_eof_o  = rd_word.word.eof;
   assign rx_chan_o = rd_word.chan;

endmodule

`default_nettype wire

// ==== verilog/status_leds.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_leds (
   input  wire                            dsp_clk,
   input  wire                            por_rst,
   input  wire                            set_stb_i,
   input  wire [rx_pkg::SET_ADDR_W-1:0]   set_addr_i,
   input  wire [rx_pkg::SET_DATA_W-1:0]   set_data_i,
   input  wire                            running_i,
   input  wire [rx_pkg::NUM_CHANNELS-1:0] overrun_i,
   output logic [rx_pkg::LED_W-1:0]       leds_o
);
   import rx_pkg::*;

   logic [LED_W-1:0] led_sw;
   logic [LED_W-1:0] led_src;
   logic [LED_W-1:0] led_hw;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         led_sw  <= '0;
         led_src <= LED_SRC_AT_RESET;
      end else if (set_stb_i) begin
         if (set_addr_i == SET_ADDR_W'(SR_MISC + 3)) begin
            led_sw <= set_data_i[LED_W-1:0];
         end
         if (set_addr_i == SET_ADDR_W'(SR_MISC + 6)) begin
            led_src <= set_data_i[LED_W-1:0];
         end
      end
   end

   // Bit 1 any running, overruns from bit 2 up
   always_comb begin
      led_hw    = '0;
      led_hw[1] = running_i;
      for (int k = 0; k < NUM_CHANNELS; k++) begin
         led_hw[2 + k] = overrun_i[k];
      end
   end

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

// ==== verilog/rx_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_core (
   input  wire                          dsp_clk,
   input  wire                          por_rst,
   input  wire                          set_stb_i,
   input  wire [rx_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  wire [rx_pkg::SET_DATA_W-1:0] set_data_i,
   input  wire [rx_pkg::ADC_W-1:0]      adc_a_i,
   input  wire [rx_pkg::ADC_W-1:0]      adc_b_i,
   output logic [2*rx_pkg::SAMPLE_W-1:0] rx_data_o,
   output logic                         rx_sof_o,
   output logic                         rx_eof_o,
   output logic [rx_pkg::CHAN_W-1:0]    rx_chan_o,
   output logic                         rx_valid_o,
   input  wire                          rx_ready_i,
   output logic [rx_pkg::LED_W-1:0]     leds_o
);
   import rx_pkg::*;

   iq_sample_t              fe_sample;
   logic [NUM_CHANNELS-1:0] running;
   logic [NUM_CHANNELS-1:0] overrun;
   logic                    any_running;

   rx_stream_if stream [NUM_CHANNELS] ();

   assign any_running = |running;   // Frontend and LED both follow this

   ////////////////////
   // ADC frontend
   rx_frontend u_frontend (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .run_i       (any_running),
      .fe_sample_o (fe_sample)
   );

   ////////////////////
   // Receive channels
   for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
      rx_channel #(
         .BASE (SR_RX_CTRL0 + g * RX_CTRL_STRIDE)
      ) u_chan (
         .dsp_clk     (dsp_clk),
         .por_rst     (por_rst),
         .set_stb_i   (set_stb_i),
         .set_addr_i  (set_addr_i),
         .set_data_i  (set_data_i),
         .fe_sample_i (fe_sample),
         .out_o       (stream[g]),
         .running_o   (running[g]),
         .overrun_o   (overrun[g])
      );
   end

   rx_merger u_merger (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .chan_i     (stream),
      .running_i  (running),
      .rx_data_o  (rx_data_o),
      .rx_sof_o   (rx_sof_o),
      .rx_eof_o   (rx_eof_o),
      .rx_chan_o  (rx_chan_o),
      .rx_valid_o (rx_valid_o),
      .rx_ready_i (rx_ready_i)
   );

   status_leds u_leds (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .running_i  (any_running),
      .overrun_i  (overrun),
      .leds_o     (leds_o)
   );

endmodule

`default_nettype wire

// ==== tb/rx_core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_core_props (
   input wire                        dsp_clk,
   input wire                        por_rst,
   input wire [2*rx_pkg::SAMPLE_W-1:0] rx_data_o,
   input wire                        rx_sof_o,
   input wire                        rx_eof_o,
   input wire [rx_pkg::CHAN_W-1:0]   rx_chan_o,
   input wire                        rx_valid_o,
   input wire                        rx_ready_i,
   input wire [rx_pkg::LED_W-1:0]    leds_o
);

   ////////////////////
   // Output stream holds while stalled
   a_data_hold: assert property (@(posedge dsp_clk) disable iff (por_rst)
      (rx_valid_o && !rx_ready_i) |=> (rx_valid_o && $stable(rx_data_o)))
      else $error("rx_data_o changed while the word was stalled");

   a_flag_hold: assert property (@(posedge dsp_clk) disable iff (por_rst)
      (rx_valid_o && !rx_ready_i) |=> ($stable(rx_sof_o) && $stable(rx_eof_o)))
      else $error("Frame flags changed while the word was stalled");

   a_chan_hold: assert property (@(posedge dsp_clk) disable iff (por_rst)
      (rx_valid_o && !rx_ready_i) |=> $stable(rx_chan_o))
      else $error("rx_chan_o changed while the word was stalled");

   ////////////////////
   // Reset state
   a_valid_reset: assert property (@(posedge dsp_clk) por_rst |=> !rx_valid_o)
      else $error("rx_valid_o high during reset");

   a_leds_reset: assert property (@(posedge dsp_clk) $fell(por_rst) |-> (leds_o == '0))
      else $error("leds_o not zero out of reset");

endmodule

bind rx_core rx_core_props u_props (
   .dsp_clk    (dsp_clk),
   .por_rst    (por_rst),
   .rx_data_o  (rx_data_o),
   .rx_sof_o   (rx_sof_o),
   .rx_eof_o   (rx_eof_o),
   .rx_chan_o  (rx_chan_o),
   .rx_valid_o (rx_valid_o),
   .rx_ready_i (rx_ready_i),
   .leds_o     (leds_o)
);

`default_nettype wire

// ==== tb/rx_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_core_tb;
   import rx_pkg::*;

   localparam int NUM_ROWS  = 6;
   localparam int WAIT_MAX  = 3000;   // Cycles allowed per wait
   localparam int QUIET_LEN = 12;
   localparam int OVR_MAX   = CHAN_FIFO_DEPTH + MERGE_FIFO_DEPTH + 1;

   typedef struct packed {
      logic [1:0]  chans;   // One bit per channel
      logic [15:0] dec;
      logic [15:0] len;     // Channel 1 runs len + 3
      logic        swap;
      logic [15:0] ofs_i;
      logic [15:0] ofs_q;
      logic [13:0] k;       // ADC B minus ADC A
      logic        stall;   // Random gaps on ready
   } row_t;

   logic                  dsp_clk    = 1'b0;
   logic                  por_rst    = 1'b1;
   logic                  set_stb_i  = 1'b0;
   logic [SET_ADDR_W-1:0] set_addr_i = '0;
   logic [SET_DATA_W-1:0] set_data_i = '0;
   logic [ADC_W-1:0]      adc_a_i    = '0;
   logic [ADC_W-1:0]      adc_b_i    = '0;
   logic                  rx_ready_i = 1'b1;
   logic [2*SAMPLE_W-1:0] rx_data_o;
   logic                  rx_sof_o;
   logic                  rx_eof_o;
   logic [CHAN_W-1:0]     rx_chan_o;
   logic                  rx_valid_o;
   logic [LED_W-1:0]      leds_o;

   logic [ADC_W-1:0] adc_cnt    = '0;
   logic [ADC_W-1:0] k_cur      = '0;
   logic [31:0]      rng        = 32'hd14c;
   int               ready_mode = 0;   // 0 high, 1 random, 2 held low
   int               errors     = 0;
   int               checks     = 0;
   int               tests_run  = 0;
   row_t             rows [NUM_ROWS];
   logic [34:0]      got_q [$];        // Chan, sof, eof, data

   rx_core UUT (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .adc_a_i    (adc_a_i),
      .adc_b_i    (adc_b_i),
      .rx_data_o  (rx_data_o),
      .rx_sof_o   (rx_sof_o),
      .rx_eof_o   (rx_eof_o),
      .rx_chan_o  (rx_chan_o),
      .rx_valid_o (rx_valid_o),
      .rx_ready_i (rx_ready_i),
      .leds_o     (leds_o)
   );

   initial begin
      forever #5 dsp_clk = ~dsp_clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   ////////////////////
   // ADC ramp and ready pattern
   always @(negedge dsp_clk) begin
      adc_cnt = adc_cnt + 1'b1;
      adc_a_i = adc_cnt;
      adc_b_i = adc_cnt + k_cur;   // Wraps at 14 bits
      rng     = xorshift32(rng);
      case (ready_mode)
         1:       rx_ready_i = rng[0];
         2:       rx_ready_i = 1'b0;
         default: rx_ready_i = 1'b1;
      endcase
   end

   // Words move on a rising edge with valid and ready
   always @(posedge dsp_clk) begin
      if (!por_rst && rx_valid_o && rx_ready_i) begin
         got_q.push_back({rx_chan_o, rx_sof_o, rx_eof_o, rx_data_o});
      end
   end

   task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic write_reg(input int addr, input logic [31:0] data);
      @(negedge dsp_clk);
      set_stb_i  = 1'b1;
      set_addr_i = SET_ADDR_W'(addr);
      set_data_i = data;
      @(negedge dsp_clk);
      set_stb_i  = 1'b0;
   endtask

   task automatic wait_words(input int n);
      int cyc;
      cyc = 0;
      while (got_q.size() < n && cyc < WAIT_MAX) begin
         @(negedge dsp_clk);
         cyc++;
      end
      if (got_q.size() < n) begin
         errors++;
         $display("Timeout: only %0d of %0d words arrived", got_q.size(), n);
      end
   endtask

   task automatic wait_quiet();
      int cyc;
      int idle;
      cyc  = 0;
      idle = 0;
      while (idle < QUIET_LEN && cyc < WAIT_MAX) begin
         @(negedge dsp_clk);
         idle = rx_valid_o ? 0 : idle + 1;
         cyc++;
      end
      if (idle < QUIET_LEN) begin
         errors++;
         $display("Timeout: the output stream never went idle");
      end
   endtask

   task automatic wait_led(input int idx, input logic val);
      int cyc;
      cyc = 0;
      while (leds_o[idx] !== val && cyc < WAIT_MAX) begin
         @(negedge dsp_clk);
         cyc++;
      end
      if (leds_o[idx] !== val) begin
         errors++;
         $display("Timeout: LED %0d never reached %0b", idx, val);
      end
   endtask

   task automatic finish_test(input string name, input int err0);
      tests_run++;
      $display("test %0d %s: %0d words, %0d mismatches", tests_run, name, got_q.size(),
               errors - err0);
   endtask

   ////////////////////
   // Table rows
   task automatic run_row(input int r);
      row_t        rw;
      int          err0;
      int          total;
      int          base;
      int          open_ch;
      int          ch;
      int          want [NUM_CHANNELS];
      int          seen [NUM_CHANNELS];
      logic [15:0] last_i [NUM_CHANNELS];
      logic [15:0] step;
      logic [15:0] rail_exp;
      logic [15:0] d_i;
      logic [15:0] d_r;
      logic [34:0] w;
      rw    = rows[r];
      err0  = errors;
      total = 0;
      got_q.delete();
      k_cur      = rw.k;
      ready_mode = rw.stall ? 1 : 0;
      write_reg(SR_RX_FRONT + 0, 32'(rw.swap));
      write_reg(SR_RX_FRONT + 1, 32'(rw.ofs_i));
      write_reg(SR_RX_FRONT + 2, 32'(rw.ofs_q));
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         want[c]   = rw.chans[c] ? int'(rw.len) + 3 * c : 0;
         seen[c]   = 0;
         last_i[c] = '0;
         total += want[c];
      end
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         if (rw.chans[c]) begin
            base = SR_RX_CTRL0 + c * RX_CTRL_STRIDE;
            write_reg(base + 0, 32'(rw.dec));
            write_reg(base + 1, 32'(want[c]));   // Starts the burst
         end
      end
      wait_words(total);
      wait_quiet();
      step = (rw.dec == '0) ? 16'd4 : {rw.dec[13:0], 2'b00};
      if (rw.swap) begin
         rail_exp = {rw.k, 2'b00} + rw.ofs_i - rw.ofs_q;
      end else begin
         rail_exp = {rw.k, 2'b00} + rw.ofs_q - rw.ofs_i;
      end
      open_ch = -1;
      for (int n = 0; n < got_q.size(); n++) begin
         w   = got_q[n];
         ch  = int'(w[34]);
         d_i = w[31:16] - last_i[ch];
         d_r = rw.swap ? w[31:16] - w[15:0] : w[15:0] - w[31:16];
         compare("channel in use", rw.chans[ch], 1);
         if (open_ch >= 0) begin
            compare("burst not interleaved", ch, open_ch);
         end
         compare("sof flag", w[33], seen[ch] == 0);
         compare("eof flag", w[32], seen[ch] == want[ch] - 1);
         if (seen[ch] > 0) begin
            compare("decimation step", d_i, step);
         end
         compare("rail difference", d_r, rail_exp);
         last_i[ch] = w[31:16];
         seen[ch]++;
         open_ch = w[32] ? -1 : ch;
      end
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         compare("word count", seen[c], want[c]);
      end
      finish_test($sformatf("row %0d", r), err0);
   endtask

   task automatic run_leds();
      int err0;
      err0 = errors;
      got_q.delete();
      compare("leds after reset", leds_o, 0);
      write_reg(SR_MISC + 3, 32'hA5);
      write_reg(SR_MISC + 6, 32'h00);
      compare("leds from software", leds_o, 32'hA5);
      write_reg(SR_MISC + 3, 32'h00);
      write_reg(SR_MISC + 6, 32'(LED_SRC_AT_RESET));
      ready_mode = 2;
      write_reg(SR_RX_CTRL0 + 0, 32'd8);   // Slow burst, stays running
      write_reg(SR_RX_CTRL0 + 1, 32'd4);
      repeat (3) @(negedge dsp_clk);
      compare("led running while stalled", leds_o[1], 1);
      ready_mode = 0;
      wait_words(4);
      wait_led(1, 1'b0);
      compare("led running after burst", leds_o[1], 0);
      wait_quiet();
      finish_test("leds", err0);
   endtask

   task automatic run_overrun();
      int err0;
      int n0;
      err0 = errors;
      got_q.delete();
      ready_mode = 2;
      write_reg(SR_RX_CTRL0 + 0, 32'd1);
      write_reg(SR_RX_CTRL0 + 1, 32'd60);   // Far beyond the buffering
      wait_led(2, 1'b1);
      compare("overrun led", leds_o[2], 1);
      compare("running ended by overrun", leds_o[1], 0);
      ready_mode = 0;
      wait_quiet();
      compare("words within buffering", got_q.size() <= OVR_MAX, 1);
      n0 = got_q.size();
      write_reg(SR_RX_CTRL0 + 1, 32'd4);
      compare("overrun led cleared", leds_o[2], 0);
      wait_words(n0 + 4);
      wait_quiet();
      finish_test("overrun", err0);
   endtask

   initial begin
      //         chans  N       len     swap  ofs_i     ofs_q     K          stall
      rows[0] = '{2'b01, 16'd1, 16'd8,  1'b0, 16'h0000, 16'h0000, 14'd5,     1'b0};
      rows[1] = '{2'b10, 16'd3, 16'd10, 1'b0, 16'h0100, 16'hFF00, 14'd100,   1'b0};
      rows[2] = '{2'b01, 16'd0, 16'd6,  1'b1, 16'h1234, 16'h0042, 14'd7,     1'b1};
      rows[3] = '{2'b10, 16'd1, 16'd13, 1'b1, 16'h8000, 16'h7FFF, 14'h3FF0,  1'b1};
      rows[4] = '{2'b11, 16'd4, 16'd12, 1'b0, 16'h0003, 16'h0009, 14'd21,    1'b1};
      rows[5] = '{2'b11, 16'd3, 16'd9,  1'b1, 16'hFFFF, 16'h0001, 14'd1000,  1'b1};
      repeat (5) @(posedge dsp_clk);
      @(negedge dsp_clk);
      por_rst = 1'b0;
      run_leds();
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(r);
      end
      run_overrun();
      $display("Tests: %0d, checks: %0d, failures: %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/rx_pkg.sv
verilog/rx_stream_if.sv
verilog/sample_fifo.sv
verilog/rx_frontend.sv
verilog/rx_channel.sv
verilog/rx_merger.sv
verilog/status_leds.sv
verilog/rx_core.sv
tb/rx_core_props.sv
tb/rx_core_tb.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = rx_core_tb
FLIST = flist.f
PASS  = No errors

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir
